// ==== lite_chan_pkg.sv ====
// AXI4-Lite read channel payload structs and response codes
package lite_chan_pkg;

  // ------------------------------
  // Field types
  // ------------------------------
  // Address and data words
  typedef logic [lite_mux_cfg_pkg::AddrWidth-1:0] addr_t;
  typedef logic [lite_mux_cfg_pkg::DataWidth-1:0] data_t;
  // Protection bits of AR
  typedef logic [2:0] prot_t;
  // Response code of R
  typedef logic [1:0] resp_t;

  // ------------------------------
  // Response codes
  // ------------------------------
  // Normal access done
  localparam resp_t RespOkay   = 2'b00;
  // Slave reports an error
  localparam resp_t RespSlvErr = 2'b10;

  // ------------------------------
  // Channel payloads
  // ------------------------------
  // Read address, 35 bits
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  // Read data, 34 bits
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

endpackage

// ==== lite_mux_cfg_pkg.sv ====
// Size configuration of the AXI4-Lite read multiplexer and its port select type
package lite_mux_cfg_pkg;

  // ------------------------------
  // Port and bus sizes
  // ------------------------------
  // Upstream ports sharing the one downstream port
  localparam int unsigned NumPorts  = 4;
  // Address and data bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // ------------------------------
  // Outstanding read limit
  // ------------------------------
  // Reads in flight between AR issue and R return
  localparam int unsigned MaxTrans  = 4;

  // ------------------------------
  // Derived widths
  // ------------------------------
  // Port index width
  localparam int unsigned SelWidth  = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  // Order queue pointer and fill count widths
  localparam int unsigned PtrWidth  = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;
  localparam int unsigned CntWidth  = $clog2(MaxTrans + 1);

  // Port index carried from arbiter to router
  typedef logic [SelWidth-1:0] sel_t;
  // Order queue pointer and count
  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

endpackage

// ==== lite_read_mux.sv ====
// Read half of an AXI4-Lite multiplexer from four upstream ports onto one downstream port
module lite_read_mux (
  input  logic                                                     clk_i,
  input  logic                                                     rst_i,
  // Upstream AR
  input  lite_chan_pkg::ar_chan_t [lite_mux_cfg_pkg::NumPorts-1:0] slv_ar_i,
  input  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_ar_valid_i,
  output logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_ar_ready_o,
  // Upstream R
  output lite_chan_pkg::r_chan_t [lite_mux_cfg_pkg::NumPorts-1:0]  slv_r_o,
  output logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_r_valid_o,
  input  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_r_ready_i,
  // Downstream AR
  output lite_chan_pkg::ar_chan_t                                  mst_ar_o,
  output logic                                                     mst_ar_valid_o,
  input  logic                                                     mst_ar_ready_i,
  // Downstream R
  input  lite_chan_pkg::r_chan_t                                   mst_r_i,
  input  logic                                                     mst_r_valid_i,
  output logic                                                     mst_r_ready_o
);

  // Arbiter output
  lite_chan_pkg::ar_chan_t arb_ar;
  lite_mux_cfg_pkg::sel_t  arb_sel;
  logic                    arb_valid, arb_ready;
  // AR after queue gating
  logic                    fwd_valid, fwd_ready;
  // Queue head towards the router
  lite_mux_cfg_pkg::sel_t  head_sel;
  logic                    head_valid, pop;
  // R spill register
  logic                    r_in_valid, r_in_ready;
  lite_chan_pkg::r_chan_t  r_out;
  logic                    r_out_valid, r_out_ready;

  // ------------------------------
  // AR path
  // ------------------------------
  rr_arbiter i_arbiter (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .req_valid_i ( slv_ar_valid_i ),
    .req_ready_o ( slv_ar_ready_o ),
    .req_i       ( slv_ar_i       ),
    .out_valid_o ( arb_valid      ),
    .out_ready_i ( arb_ready      ),
    .out_o       ( arb_ar         ),
    .out_sel_o   ( arb_sel        )
  );

  read_order_queue i_order_queue (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .in_valid_i   ( arb_valid  ),
    .in_ready_o   ( arb_ready  ),
    .in_sel_i     ( arb_sel    ),
    .fwd_valid_o  ( fwd_valid  ),
    .fwd_ready_i  ( fwd_ready  ),
    .head_sel_o   ( head_sel   ),
    .head_valid_o ( head_valid ),
    .pop_i        ( pop        )
  );

  spill_register #(
    .T ( lite_chan_pkg::ar_chan_t )
  ) i_ar_spill (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .valid_i ( fwd_valid      ),
    .ready_o ( fwd_ready      ),
    .data_i  ( arb_ar         ),
    .valid_o ( mst_ar_valid_o ),
    .ready_i ( mst_ar_ready_i ),
    .data_o  ( mst_ar_o       )
  );

  // ------------------------------
  // R path
  // ------------------------------
  // No R accepted while no read is outstanding
  assign r_in_valid    = mst_r_valid_i & head_valid;
  assign mst_r_ready_o = r_in_ready & head_valid;

  spill_register #(
    .T ( lite_chan_pkg::r_chan_t )
  ) i_r_spill (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( r_in_valid  ),
    .ready_o ( r_in_ready  ),
    .data_i  ( mst_r_i     ),
    .valid_o ( r_out_valid ),
    .ready_i ( r_out_ready ),
    .data_o  ( r_out       )
  );

  r_router i_router (
    .r_valid_i     ( r_out_valid   ),
    .r_ready_o     ( r_out_ready   ),
    .r_i           ( r_out         ),
    .head_sel_i    ( head_sel      ),
    .head_valid_i  ( head_valid    ),
    .pop_o         ( pop           ),
    .slv_r_o       ( slv_r_o       ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i )
  );

endmodule

// ==== project.f ====
lite_mux_cfg_pkg.sv
lite_chan_pkg.sv
rr_arbiter.sv
read_order_queue.sv
spill_register.sv
r_router.sv
lite_read_mux.sv
tb_lite_mem.sv
tb_lite_read_mux.sv

// ==== r_router.sv ====
// Steers each downstream R beat to the port at the head of the order queue
module r_router (
  // R beat out of the spill register
  input  logic                                                    r_valid_i,
  output logic                                                    r_ready_o,
  input  lite_chan_pkg::r_chan_t                                  r_i,
  // Oldest outstanding select
  input  lite_mux_cfg_pkg::sel_t                                  head_sel_i,
  input  logic                                                    head_valid_i,
  output logic                                                    pop_o,
  // Upstream R ports
  output lite_chan_pkg::r_chan_t [lite_mux_cfg_pkg::NumPorts-1:0] slv_r_o,
  output logic [lite_mux_cfg_pkg::NumPorts-1:0]                   slv_r_valid_o,
  input  logic [lite_mux_cfg_pkg::NumPorts-1:0]                   slv_r_ready_i
);

  // ------------------------------
  // Fan-out
  // ------------------------------
  // Payload goes to every port, valid only to the head one
  for (genvar i = 0; i < lite_mux_cfg_pkg::NumPorts; i++) begin : gen_slv_r
    assign slv_r_o[i]       = r_i;
    assign slv_r_valid_o[i] = r_valid_i & head_valid_i &
                              (head_sel_i == lite_mux_cfg_pkg::sel_t'(i));
  end

  // ------------------------------
  // Back-pressure and pop
  // ------------------------------
  // Ready follows the head port only
  assign r_ready_o = head_valid_i & slv_r_ready_i[head_sel_i];
  // Read complete once the beat is taken upstream
  assign pop_o     = r_valid_i & r_ready_o;

endmodule

// ==== read_order_queue.sv ====
// Order queue of port selects that gates AR issue and routes returning reads
module read_order_queue (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Arbitrated request from the arbiter
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  lite_mux_cfg_pkg::sel_t in_sel_i,
  // Forwarded handshake to the AR spill register
  output logic                   fwd_valid_o,
  input  logic                   fwd_ready_i,
  // Oldest outstanding select for the R router
  output lite_mux_cfg_pkg::sel_t head_sel_o,
  output logic                   head_valid_o,
  input  logic                   pop_i
);

  // Select storage, one entry per outstanding read
  lite_mux_cfg_pkg::sel_t mem_q [lite_mux_cfg_pkg::MaxTrans];
  lite_mux_cfg_pkg::ptr_t wr_ptr_q;
  lite_mux_cfg_pkg::ptr_t rd_ptr_q;
  lite_mux_cfg_pkg::cnt_t cnt_q;
  logic                   full;
  logic                   push;

  // ------------------------------
  // Issue gating
  // ------------------------------
  assign full        = (cnt_q == lite_mux_cfg_pkg::cnt_t'(lite_mux_cfg_pkg::MaxTrans));
  // Pass the handshake only while space is left
  assign fwd_valid_o = in_valid_i & ~full;
  assign in_ready_o  = fwd_ready_i & ~full;
  // Record the select when the AR leaves
  assign push        = fwd_valid_o & fwd_ready_i;

  // Head of the queue
  assign head_valid_o = (cnt_q != '0);
  assign head_sel_o   = mem_q[rd_ptr_q];

  // ------------------------------
  // Pointers and count
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        // Wrap at the depth, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == lite_mux_cfg_pkg::ptr_t'(lite_mux_cfg_pkg::MaxTrans - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == lite_mux_cfg_pkg::ptr_t'(lite_mux_cfg_pkg::MaxTrans - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({push, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Select write
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_sel_i;
    end
  end

endmodule

// ==== rr_arbiter.sv ====
// Round-robin arbiter with lock-in that picks one upstream AR request at a time
module rr_arbiter (
  input  logic                                                     clk_i,
  input  logic                                                     rst_i,
  // Upstream AR requests, one per port
  input  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    req_valid_i,
  output logic [lite_mux_cfg_pkg::NumPorts-1:0]                    req_ready_o,
  input  lite_chan_pkg::ar_chan_t [lite_mux_cfg_pkg::NumPorts-1:0] req_i,
  // Granted request towards the order queue
  output logic                                                     out_valid_o,
  input  logic                                                     out_ready_i,
  output lite_chan_pkg::ar_chan_t                                  out_o,
  output lite_mux_cfg_pkg::sel_t                                   out_sel_o
);

  // Index of the last port that completed a transfer
  lite_mux_cfg_pkg::sel_t last_q;
  // Choice held while the output stalls
  logic                   locked_q;
  lite_mux_cfg_pkg::sel_t lock_sel_q;
  // Fresh round-robin pick and the select in use
  lite_mux_cfg_pkg::sel_t rr_sel;
  lite_mux_cfg_pkg::sel_t sel;

  // ------------------------------
  // Round-robin search
  // ------------------------------
  // Lowest requesting index after last_q, wrapping around
  always_comb begin : p_rr_search
    int unsigned idx;
    logic        hit;
    rr_sel = last_q;
    hit    = 1'b0;
    // Offset NumPorts comes back to last_q itself
    for (int unsigned off = 1; off <= lite_mux_cfg_pkg::NumPorts; off++) begin
      idx = (last_q + off) % lite_mux_cfg_pkg::NumPorts;
      if (!hit && req_valid_i[idx]) begin
        rr_sel = lite_mux_cfg_pkg::sel_t'(idx);
        hit    = 1'b1;
      end
    end
  end

  // Stalled choice wins over a fresh pick
  assign sel = locked_q ? lock_sel_q : rr_sel;

  // ------------------------------
  // Output mux
  // ------------------------------
  // No requester means rr_sel == last_q, which is idle
  assign out_valid_o = req_valid_i[sel];
  assign out_o       = req_i[sel];
  assign out_sel_o   = sel;

  // Ready only back to the granted port
  for (genvar i = 0; i < lite_mux_cfg_pkg::NumPorts; i++) begin : gen_ready
    assign req_ready_o[i] = out_valid_o & out_ready_i &
                            (sel == lite_mux_cfg_pkg::sel_t'(i));
  end

  // ------------------------------
  // Pointer and lock state
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Port 0 goes first after reset
      last_q   <= lite_mux_cfg_pkg::sel_t'(lite_mux_cfg_pkg::NumPorts - 1);
      locked_q <= 1'b0;
    end else if (out_valid_o && out_ready_i) begin
      // Transfer done, move the pointer and release
      last_q   <= sel;
      locked_q <= 1'b0;
    end else if (out_valid_o) begin
      // Offered but not taken, hold the choice
      locked_q <= 1'b1;
    end
  end

  // Capture the pick while unlocked
  always_ff @(posedge clk_i) begin
    if (!locked_q) begin
      lock_sel_q <= rr_sel;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log says so
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_lite_read_mux -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench passed" sim.log \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }

// ==== spill_register.sv ====
// Two-entry valid/ready register slice that cuts all paths between its sides
module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  // Input side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Output side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new data, slot B catches it on an output stall
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;
  // Slot events
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // ------------------------------
  // Slot control
  // ------------------------------
  // Accept while at least one slot is free
  assign ready_o = ~a_full_q | ~b_full_q;
  assign a_fill  = valid_i & ready_o;
  // A empties whenever B is free, out or into B
  assign a_drain = a_full_q & ~b_full_q;
  // A spills into B when the output stalls
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  // B holds the older beat
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // ------------------------------
  // State
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      // Refill in the same cycle keeps A full
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule

// ==== tb_lite_mem.sv ====
// Downstream AXI4-Lite read slave model that answers with the inverted address
module tb_lite_mem (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Random gating of ar_ready and R start
  input  logic                    rand_en_i,
  // Stall all R beats while high
  input  logic                    hold_i,
  // AR from the mux
  input  lite_chan_pkg::ar_chan_t ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  // R towards the mux
  output lite_chan_pkg::r_chan_t  r_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Accepted addresses waiting for their R beat
  lite_chan_pkg::addr_t pend_q [$];
  int                   seed = 91;
  logic [31:0]          rnd_ar;
  logic [31:0]          rnd_r;

  // Slave rule: data is ~addr, top nibble F means SLVERR
  function automatic lite_chan_pkg::r_chan_t answer(input lite_chan_pkg::addr_t a);
    lite_chan_pkg::r_chan_t r;
    r.data = ~a;
    if (a[lite_mux_cfg_pkg::AddrWidth-1 -: 4] == 4'hF) begin
      r.resp = lite_chan_pkg::RespSlvErr;
    end else begin
      r.resp = lite_chan_pkg::RespOkay;
    end
    return r;
  endfunction

  always @(posedge clk_i) begin
    rnd_ar = $random(seed);
    rnd_r  = $random(seed);
    if (rst_i) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_o        <= '0;
      pend_q.delete();
    end else begin
      // Take the address first so an empty queue can answer at once
      if (ar_valid_i && ar_ready_o) begin
        pend_q.push_back(ar_i.addr);
      end
      ar_ready_o <= !rand_en_i || rnd_ar[0];
      // One beat at a time, in order
      if (r_valid_o) begin
        if (r_ready_i) begin
          void'(pend_q.pop_front());
          r_valid_o <= 1'b0;
        end
      end else if (pend_q.size() != 0 && !hold_i && (!rand_en_i || rnd_r[1])) begin
        r_o       <= answer(pend_q[0]);
        r_valid_o <= 1'b1;
      end
    end
  end

endmodule

// ==== tb_lite_read_mux.sv ====
// Testbench for the AXI4-Lite read multiplexer with table stimulus and scoreboards
module tb_lite_read_mux;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumRows    = 20;
  localparam int CycleLimit = NumRows * 40 + 100;

  // One read of the table
  typedef struct packed {
    lite_mux_cfg_pkg::sel_t  port;
    lite_chan_pkg::ar_chan_t ar;
    lite_chan_pkg::r_chan_t  exp;
  } row_t;

  logic clk;
  logic rst;
  logic strict;
  logic hold;
  lite_chan_pkg::ar_chan_t [lite_mux_cfg_pkg::NumPorts-1:0] slv_ar;
  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_ar_valid;
  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_ar_ready;
  lite_chan_pkg::r_chan_t [lite_mux_cfg_pkg::NumPorts-1:0]  slv_r;
  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_r_valid;
  logic [lite_mux_cfg_pkg::NumPorts-1:0]                    slv_r_ready;
  lite_chan_pkg::ar_chan_t mst_ar;
  logic                    mst_ar_valid;
  logic                    mst_ar_ready;
  lite_chan_pkg::r_chan_t  mst_r;
  logic                    mst_r_valid;
  logic                    mst_r_ready;

  // ------------------------------
  // Scoreboard state
  // ------------------------------
  row_t                    tbl [NumRows];
  int                      row_fill = 0;
  lite_chan_pkg::r_chan_t  exp_r [lite_mux_cfg_pkg::NumPorts][$];
  lite_chan_pkg::ar_chan_t ar_exp [$];
  int                      ar_cyc [$];
  int                      cycle = 0;
  int                      outstanding = 0;
  int                      last_grant = lite_mux_cfg_pkg::NumPorts - 1;
  logic                    all_run = 1'b0;
  int                      seed = 91;
  logic [31:0]             rnd;
  logic [lite_mux_cfg_pkg::NumPorts-1:0]                   prev_valid = '0;
  logic [lite_mux_cfg_pkg::NumPorts-1:0]                   prev_ready = '0;
  lite_chan_pkg::r_chan_t [lite_mux_cfg_pkg::NumPorts-1:0] prev_r;

  lite_read_mux i_dut (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_r_o        ( slv_r        ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_o       ( mst_ar       ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_i        ( mst_r        ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  )
  );

  tb_lite_mem i_mem (
    .clk_i      ( clk          ),
    .rst_i      ( rst          ),
    .rand_en_i  ( !strict      ),
    .hold_i     ( hold         ),
    .ar_i       ( mst_ar       ),
    .ar_valid_i ( mst_ar_valid ),
    .ar_ready_o ( mst_ar_ready ),
    .r_o        ( mst_r        ),
    .r_valid_o  ( mst_r_valid  ),
    .r_ready_i  ( mst_r_ready  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Helpers and checks
  // ------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_ar(input string name, input lite_chan_pkg::ar_chan_t got,
                          input lite_chan_pkg::ar_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_r(input string name, input lite_chan_pkg::r_chan_t got,
                         input lite_chan_pkg::r_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  // Expected R from the slave rule
  function automatic lite_chan_pkg::r_chan_t expect_r(input lite_chan_pkg::addr_t a);
    lite_chan_pkg::r_chan_t r;
    r.data = ~a;
    r.resp = (a[lite_mux_cfg_pkg::AddrWidth-1 -: 4] == 4'hF) ?
             lite_chan_pkg::RespSlvErr : lite_chan_pkg::RespOkay;
    return r;
  endfunction

  task automatic add_row(input int p, input lite_chan_pkg::addr_t a);
    tbl[row_fill].port    = lite_mux_cfg_pkg::sel_t'(p);
    tbl[row_fill].ar.addr = a;
    tbl[row_fill].ar.prot = lite_chan_pkg::prot_t'(row_fill);
    tbl[row_fill].exp     = expect_r(a);
    row_fill++;
  endtask

  // Issue the rows of one port in the given range and hold valid until taken
  task automatic drive_port(input int p, input int first, input int last);
    for (int r = first; r <= last; r++) begin
      if (int'(tbl[r].port) == p) begin
        slv_ar[p]       <= tbl[r].ar;
        slv_ar_valid[p] <= 1'b1;
        @(posedge clk);
        while (!slv_ar_ready[p]) begin
          @(posedge clk);
        end
        exp_r[p].push_back(tbl[r].exp);
      end
    end
    slv_ar_valid[p] <= 1'b0;
  endtask

  task automatic wait_drained();
    while (ar_exp.size() != 0 || exp_r[0].size() != 0 || exp_r[1].size() != 0 ||
           exp_r[2].size() != 0 || exp_r[3].size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Random upstream R back-pressure outside the strict phase
  always @(posedge clk) begin
    rnd = $random(seed);
    if (rst || strict) begin
      slv_r_ready <= '1;
    end else begin
      slv_r_ready <= rnd[3:0];
    end
  end

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(posedge clk) begin : p_monitor
    int gap;
    int exp_port;
    lite_chan_pkg::r_chan_t want;
    cycle++;
    if (cycle >= CycleLimit) begin
      abort_run($sformatf("Timeout after %0d cycles with reads still pending", cycle));
    end
    if (!rst) begin
      // Round-robin window opens when idle and closes on a partial request set
      if (slv_ar_valid == '0) begin
        all_run = 1'b1;
      end else if (!(&slv_ar_valid)) begin
        all_run = 1'b0;
      end
      for (int p = 0; p < lite_mux_cfg_pkg::NumPorts; p++) begin
        if (slv_ar_valid[p] && slv_ar_ready[p]) begin
          if (all_run && (&slv_ar_valid)) begin
            exp_port = (last_grant + 1) % lite_mux_cfg_pkg::NumPorts;
            check_bit($sformatf("slv_ar_ready_o[%0d] round-robin", exp_port),
                      slv_ar_ready[exp_port], 1'b1);
          end
          last_grant = p;
          all_run    = 1'b1;
          ar_exp.push_back(slv_ar[p]);
          ar_cyc.push_back(cycle);
        end
      end
      // Downstream order and latency
      if (mst_ar_valid && mst_ar_ready) begin
        if (ar_exp.size() == 0) begin
          abort_run("An AR left the mux with no matching upstream request");
        end
        check_ar("mst_ar_o", mst_ar, ar_exp.pop_front());
        gap = cycle - ar_cyc.pop_front();
        if (strict && gap != 1) begin
          abort_run($sformatf("AR reached the downstream port %0d cycles late, not 1", gap));
        end
        outstanding++;
      end
      if (mst_r_valid && mst_r_ready) begin
        outstanding--;
      end
      if (outstanding > int'(lite_mux_cfg_pkg::MaxTrans)) begin
        abort_run($sformatf("%0d reads are outstanding downstream, more than the limit %0d",
                            outstanding, lite_mux_cfg_pkg::MaxTrans));
      end
      if ($countones(slv_r_valid) > 1) begin
        abort_run("More than one upstream port sees an R beat at the same time");
      end
      // Upstream R stability and data
      for (int p = 0; p < lite_mux_cfg_pkg::NumPorts; p++) begin
        if (prev_valid[p] && !prev_ready[p]) begin
          check_bit($sformatf("slv_r_valid_o[%0d]", p), slv_r_valid[p], 1'b1);
          check_r($sformatf("slv_r_o[%0d] held", p), slv_r[p], prev_r[p]);
        end
        if (slv_r_valid[p] && slv_r_ready[p]) begin
          if (exp_r[p].size() == 0) begin
            abort_run($sformatf("Port %0d got an R beat it never asked for", p));
          end
          want = exp_r[p].pop_front();
          check_r($sformatf("slv_r_o[%0d]", p), slv_r[p], want);
        end
        prev_valid[p] = slv_r_valid[p];
        prev_ready[p] = slv_r_ready[p];
        prev_r[p]     = slv_r[p];
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    rst          = 1'b1;
    strict       = 1'b1;
    hold         = 1'b0;
    slv_ar       = '0;
    slv_ar_valid = '0;
    slv_r_ready  = '1;
    // Single reads, then two per port, then eight under R hold
    add_row(0, 32'h0000_0100);
    add_row(1, 32'h1000_0200);
    add_row(2, 32'h2000_0300);
    add_row(3, 32'h3000_0400);
    for (int i = 0; i < 8; i++) begin
      add_row(i % 4, (i == 5) ? 32'hF000_0020 : 32'h4000_0010 + 32'(i * 16));
    end
    for (int i = 0; i < 8; i++) begin
      add_row(i % 4, (i == 6) ? 32'hFFFF_FFF0 : 32'h6000_0000 + 32'(i * 4));
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Idle after reset
    check_bit("slv_r_valid_o", |slv_r_valid, 1'b0);
    check_bit("mst_ar_valid_o", mst_ar_valid, 1'b0);
    check_bit("slv_ar_ready_o", |slv_ar_ready, 1'b0);
    check_bit("mst_r_ready_o", mst_r_ready, 1'b0);
    for (int r = 0; r < 4; r++) begin
      drive_port(int'(tbl[r].port), r, r);
      wait_drained();
    end
    strict <= 1'b0;
    fork
      drive_port(0, 4, 11);
      drive_port(1, 4, 11);
      drive_port(2, 4, 11);
      drive_port(3, 4, 11);
    join
    wait_drained();
    hold <= 1'b1;
    fork
      drive_port(0, 12, 19);
      drive_port(1, 12, 19);
      drive_port(2, 12, 19);
      drive_port(3, 12, 19);
      begin
        // Release once the limit has been reached
        while (outstanding < int'(lite_mux_cfg_pkg::MaxTrans)) begin
          @(posedge clk);
        end
        repeat (10) @(posedge clk);
        hold <= 1'b0;
      end
    join
    wait_drained();
    $display("Testbench passed");
    $finish;
  end

endmodule
